//--- src/rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [11:0] csr_addr_t;

	// ======================================================================
	// instruction classes and ALU operations
	// ======================================================================
	typedef enum logic [3:0] {
		op_reg,
		op_imm,
		lui,
		auipc,
		jal,
		jalr,
		branch,
		system,
		illegal
	} inst_class_e;

	// prefixed since and, or and xor are reserved words
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// ======================================================================
	// opcodes, fixed instruction words and machine CSRs
	// ======================================================================
	localparam logic [6:0] OPC_REG    = 7'b0110011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam xlen_t INST_ECALL  = 32'h0000_0073;
	localparam xlen_t INST_EBREAK = 32'h0010_0073;
	localparam xlen_t INST_MRET   = 32'h3020_0073;

	localparam csr_addr_t CSR_MSTATUS = 12'h300;
	localparam csr_addr_t CSR_MTVEC   = 12'h305;
	localparam csr_addr_t CSR_MEPC    = 12'h341;
	localparam csr_addr_t CSR_MCAUSE  = 12'h342;

	localparam xlen_t RESET_PC      = 32'h8000_0000;
	localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

//--- src/decode_if.sv
interface decode_if import rv_pkg::*; ();

	inst_class_e cls;
	alu_op_e     alu_op;
	reg_addr_t   rd;
	reg_addr_t   rs1;
	reg_addr_t   rs2;
	logic [2:0]  funct3;
	xlen_t       imm; // sign extended, csr address sits in imm[11:0]
	logic        rd_we;
	logic        is_csr;
	logic        is_ecall;
	logic        is_mret;
	logic        is_ebreak;

	modport src (
		output cls, alu_op, rd, rs1, rs2, funct3, imm,
		output rd_we, is_csr, is_ecall, is_mret, is_ebreak
	);

	modport sink (
		input cls, alu_op, rd, rs1, rs2, funct3, imm,
		input rd_we, is_csr, is_ecall, is_mret, is_ebreak
	);

endinterface

//--- src/decoder.sv
module decoder import rv_pkg::*; (
	input xlen_t inst,
	decode_if.src dec
);

	logic [6:0] opcode;
	logic [6:0] funct7;
	xlen_t imm_i;
	xlen_t imm_b;
	xlen_t imm_u;
	xlen_t imm_j;

	assign opcode = inst[6:0];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign dec.rd = inst[11:7];
	assign dec.rs1 = inst[19:15];
	assign dec.rs2 = inst[24:20];
	assign dec.funct3 = inst[14:12];

	assign dec.is_ecall = (inst == INST_ECALL);
	assign dec.is_mret = (inst == INST_MRET);
	assign dec.is_ebreak = (inst == INST_EBREAK);
	assign dec.is_csr = (opcode == OPC_SYSTEM) && (inst[13:12] != 2'b00) && !inst[14]; // register forms only

	always_comb begin
		dec.cls = illegal;
		dec.imm = imm_i;
		case (opcode)
			OPC_REG:    dec.cls = op_reg;
			OPC_IMM:    dec.cls = op_imm;
			OPC_LUI:    begin dec.cls = lui;    dec.imm = imm_u; end
			OPC_AUIPC:  begin dec.cls = auipc;  dec.imm = imm_u; end
			OPC_JAL:    begin dec.cls = jal;    dec.imm = imm_j; end
			OPC_JALR:   dec.cls = jalr;
			OPC_BRANCH: begin dec.cls = branch; dec.imm = imm_b; end
			OPC_SYSTEM: dec.cls = system;
			default:    dec.cls = illegal;
		endcase
	end

	// funct7 bit 5 picks sub and sra, immediates never subtract
	always_comb begin
		case (inst[14:12])
			3'b000:  dec.alu_op = (opcode == OPC_REG && funct7[5]) ? alu_sub : alu_add;
			3'b001:  dec.alu_op = alu_sll;
			3'b010:  dec.alu_op = alu_slt;
			3'b011:  dec.alu_op = alu_sltu;
			3'b100:  dec.alu_op = alu_xor;
			3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
			3'b110:  dec.alu_op = alu_or;
			default: dec.alu_op = alu_and;
		endcase
	end

	assign dec.rd_we = (dec.cls inside {op_reg, op_imm, lui, auipc, jal, jalr}) || dec.is_csr;

endmodule

//--- src/reg_file.sv
module reg_file import rv_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output xlen_t     rdata1,
	output xlen_t     rdata2,
	input  logic      we,
	input  reg_addr_t waddr,
	input  xlen_t     wdata,
	output xlen_t     halt_ret
);

	xlen_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];
	assign halt_ret = regs[10]; // a0 carries the program's return value

	a_waddr_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		we |-> !$isunknown(waddr)
	);

endmodule

//--- src/alu_unit.sv
module alu_unit import rv_pkg::*; (
	decode_if.sink dec,
	input  xlen_t  pc,
	input  xlen_t  src1,
	input  xlen_t  src2,
	output xlen_t  alu_result,
	output xlen_t  target,
	output logic   redirect
);

	xlen_t op_b;
	xlen_t alu_out;
	logic [4:0] shamt;
	logic taken;

	assign op_b = (dec.cls == op_reg) ? src2 : dec.imm;
	assign shamt = op_b[4:0];

	// ======================================================================
	// arithmetic and logic
	// ======================================================================
	always_comb begin
		case (dec.alu_op)
			alu_add:  alu_out = src1 + op_b;
			alu_sub:  alu_out = src1 - op_b;
			alu_sll:  alu_out = src1 << shamt;
			alu_slt:  alu_out = {31'b0, $signed(src1) < $signed(op_b)};
			alu_sltu: alu_out = {31'b0, src1 < op_b};
			alu_xor:  alu_out = src1 ^ op_b;
			alu_srl:  alu_out = src1 >> shamt;
			alu_sra:  alu_out = xlen_t'($signed(src1) >>> shamt);
			alu_or:   alu_out = src1 | op_b;
			default:  alu_out = src1 & op_b;
		endcase
	end

	always_comb begin
		case (dec.cls)
			op_reg, op_imm: alu_result = alu_out;
			lui:            alu_result = dec.imm;
			auipc:          alu_result = pc + dec.imm;
			jal, jalr:      alu_result = pc + 32'd4; // link value
			default:        alu_result = '0;
		endcase
	end

	// ======================================================================
	// branches and jumps
	// ======================================================================
	always_comb begin
		case (dec.funct3)
			3'b000:  taken = (src1 == src2);
			3'b001:  taken = (src1 != src2);
			3'b100:  taken = ($signed(src1) < $signed(src2));
			3'b101:  taken = ($signed(src1) >= $signed(src2));
			3'b110:  taken = (src1 < src2);
			3'b111:  taken = (src1 >= src2);
			default: taken = 1'b0;
		endcase
	end

	assign target = (dec.cls == jalr) ? ((src1 + dec.imm) & ~32'd1) : (pc + dec.imm);
	assign redirect = (dec.cls == jal) || (dec.cls == jalr) || (dec.cls == branch && taken);

endmodule

//--- src/csr_unit.sv
module csr_unit import rv_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   inst_valid,
	decode_if.sink dec,
	input  xlen_t  pc,
	input  xlen_t  src1,
	output xlen_t  csr_rdata,
	output xlen_t  trap_target,
	output logic   trap_redirect
);

	xlen_t mstatus;
	xlen_t mtvec;
	xlen_t mepc;
	xlen_t mcause;
	xlen_t csr_old;
	xlen_t csr_new;
	csr_addr_t csr_addr;
	logic csr_we;

	assign csr_addr = dec.imm[11:0];

	always_comb begin
		case (csr_addr)
			CSR_MSTATUS: csr_old = mstatus;
			CSR_MTVEC:   csr_old = mtvec;
			CSR_MEPC:    csr_old = mepc;
			CSR_MCAUSE:  csr_old = mcause;
			default:     csr_old = '0;
		endcase
	end

	always_comb begin
		case (dec.funct3[1:0])
			2'b01:   csr_new = src1;            // csrrw
			2'b10:   csr_new = csr_old | src1;  // csrrs
			default: csr_new = csr_old & ~src1; // csrrc
		endcase
	end

	// set and clear with x0 as source only read the csr
	assign csr_we = inst_valid && dec.is_csr && (dec.funct3[1:0] == 2'b01 || dec.rs1 != 5'd0);
	assign csr_rdata = dec.is_csr ? csr_old : '0;

	assign trap_redirect = dec.is_ecall || dec.is_mret;
	assign trap_target = dec.is_ecall ? mtvec : mepc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mstatus <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (inst_valid && dec.is_ecall) begin
			mepc <= pc;
			mcause <= CAUSE_ECALL_M;
		end else if (csr_we) begin
			case (csr_addr)
				CSR_MSTATUS: mstatus <= csr_new;
				CSR_MTVEC:   mtvec <= csr_new;
				CSR_MEPC:    mepc <= csr_new;
				CSR_MCAUSE:  mcause <= csr_new;
				default:     ;
			endcase
		end
	end

	a_trap_no_csr_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(trap_redirect && csr_we)
	);

endmodule

//--- src/commit_merge.sv
module commit_merge import rv_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      inst_valid,
	decode_if.sink    dec,
	input  xlen_t     alu_result,
	input  xlen_t     target,
	input  logic      redirect,
	input  xlen_t     csr_rdata,
	input  xlen_t     trap_target,
	input  logic      trap_redirect,
	output xlen_t     pc,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output xlen_t     wb_data,
	output logic      finished
);

	xlen_t next_pc;

	// trap entry and return take priority over jumps and branches
	always_comb begin
		if (trap_redirect) begin
			next_pc = trap_target;
		end else if (redirect) begin
			next_pc = target;
		end else begin
			next_pc = pc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (inst_valid) begin
			pc <= next_pc; // pc holds while the fetch port stalls
		end
	end

	assign wb_en = inst_valid && dec.rd_we;
	assign wb_addr = dec.rd;
	assign wb_data = dec.is_csr ? csr_rdata : alu_result;
	assign finished = inst_valid && dec.is_ebreak;

	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00
	);

endmodule

//--- src/rv_core.sv
module rv_core import rv_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      inst_valid,
	input  xlen_t     inst,
	output xlen_t     pc,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output xlen_t     wb_data,
	output logic      finished,
	output xlen_t     halt_ret
);

	xlen_t src1;
	xlen_t src2;
	xlen_t alu_result;
	xlen_t target;
	logic redirect;
	xlen_t csr_rdata;
	xlen_t trap_target;
	logic trap_redirect;

	decode_if dec_if ();

	decoder decoder_i (
		.inst (inst),
		.dec  (dec_if.src)
	);

	reg_file reg_file_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.raddr1   (dec_if.rs1),
		.raddr2   (dec_if.rs2),
		.rdata1   (src1),
		.rdata2   (src2),
		.we       (wb_en),
		.waddr    (wb_addr),
		.wdata    (wb_data),
		.halt_ret (halt_ret)
	);

	// ======================================================================
	// execution units side by side on the same decoded instruction
	// ======================================================================
	alu_unit alu_unit_i (
		.dec        (dec_if.sink),
		.pc         (pc),
		.src1       (src1),
		.src2       (src2),
		.alu_result (alu_result),
		.target     (target),
		.redirect   (redirect)
	);

	csr_unit csr_unit_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.inst_valid    (inst_valid),
		.dec           (dec_if.sink),
		.pc            (pc),
		.src1          (src1),
		.csr_rdata     (csr_rdata),
		.trap_target   (trap_target),
		.trap_redirect (trap_redirect)
	);

	commit_merge commit_merge_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.inst_valid    (inst_valid),
		.dec           (dec_if.sink),
		.alu_result    (alu_result),
		.target        (target),
		.redirect      (redirect),
		.csr_rdata     (csr_rdata),
		.trap_target   (trap_target),
		.trap_redirect (trap_redirect),
		.pc            (pc),
		.wb_en         (wb_en),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.finished      (finished)
	);

endmodule

//--- tests/clock_gen.sv
module clock_gen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		#5 arst_n = 1'b1; // released off the edge like every other input
	end

endmodule

//--- tests/rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		int        beh;
		xlen_t     word;
		logic      valid;
		logic      wb_en;
		reg_addr_t wb_addr;
		xlen_t     wb_data;
		xlen_t     pc_after;
		logic      fin;
		logic      chk_halt;
		xlen_t     halt;
	} row_t;

	logic clk;
	logic arst_n;
	logic inst_valid;
	xlen_t inst;
	xlen_t pc;
	logic wb_en;
	reg_addr_t wb_addr;
	xlen_t wb_data;
	logic finished;
	xlen_t halt_ret;

	row_t rows[$];
	int errors = 0;
	int beh_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int cycle_limit = 0;
	string beh_names [6] = '{"arithmetic and logic", "control flow", "csr access",
		"trap and return", "stall", "halt"};

	clock_gen clock_gen_i (.clk(clk), .arst_n(arst_n));

	rv_core dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.finished   (finished),
		.halt_ret   (halt_ret)
	);

	// ======================================================================
	// instruction encoders and table rows
	// ======================================================================
	function automatic xlen_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
			logic [2:0] f3, reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_REG};
	endfunction

	function automatic xlen_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
			reg_addr_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic xlen_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic xlen_t u_type(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic xlen_t j_type(logic [20:0] imm, reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic write_row(int beh, xlen_t word, reg_addr_t rd, xlen_t data, xlen_t pc_after);
		row_t r;
		r = '{beh, word, 1'b1, 1'b1, rd, data, pc_after, 1'b0, 1'b0, '0};
		rows.push_back(r);
	endtask

	task automatic flow_row(int beh, xlen_t word, xlen_t pc_after);
		row_t r;
		r = '{beh, word, 1'b1, 1'b0, 5'd0, '0, pc_after, 1'b0, 1'b0, '0};
		rows.push_back(r);
	endtask

	task automatic stall_row(int beh, xlen_t word, xlen_t pc_after);
		row_t r;
		r = '{beh, word, 1'b0, 1'b0, 5'd0, '0, pc_after, 1'b0, 1'b0, '0};
		rows.push_back(r);
	endtask

	task automatic halt_row(int beh, xlen_t pc_after, xlen_t ret);
		row_t r;
		r = '{beh, 32'h0010_0073, 1'b1, 1'b0, 5'd0, '0, pc_after, 1'b1, 1'b1, ret};
		rows.push_back(r);
	endtask

	task automatic build_table();
		write_row(1, i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_IMM), 5'd1, 32'd5, 32'h8000_0004);
		write_row(1, i_type(12'hffd, 5'd0, 3'b000, 5'd2, OPC_IMM), 5'd2, 32'hffff_fffd,
			32'h8000_0008);
		write_row(1, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd2, 32'h8000_000c);
		write_row(1, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'd8, 32'h8000_0010);
		write_row(1, i_type(12'd4, 5'd1, 3'b001, 5'd5, OPC_IMM), 5'd5, 32'h50, 32'h8000_0014);
		write_row(1, i_type(12'h401, 5'd2, 3'b101, 5'd6, OPC_IMM), 5'd6, 32'hffff_fffe,
			32'h8000_0018);
		write_row(1, r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd7), 5'd7, 32'h07ff_ffff,
			32'h8000_001c);
		write_row(1, r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 5'd8, 32'd1, 32'h8000_0020);
		write_row(1, r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd9), 5'd9, 32'd0, 32'h8000_0024);
		write_row(1, u_type(20'h12345, 5'd10, OPC_LUI), 5'd10, 32'h1234_5000, 32'h8000_0028);
		write_row(1, u_type(20'h00001, 5'd11, OPC_AUIPC), 5'd11, 32'h8000_1028, 32'h8000_002c);
		write_row(1, i_type(12'd7, 5'd1, 3'b000, 5'd0, OPC_IMM), 5'd0, 32'd12, 32'h8000_0030);
		write_row(1, r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd12), 5'd12, 32'd5, 32'h8000_0034);
		flow_row(2, b_type(13'd8, 5'd12, 5'd1, 3'b000), 32'h8000_003c); // beq taken
		flow_row(2, b_type(13'd8, 5'd12, 5'd1, 3'b001), 32'h8000_0040); // bne not taken
		flow_row(2, b_type(13'd12, 5'd1, 5'd2, 3'b100), 32'h8000_004c);
		flow_row(2, b_type(13'd8, 5'd1, 5'd2, 3'b111), 32'h8000_0054);
		flow_row(2, b_type(13'd8, 5'd1, 5'd2, 3'b101), 32'h8000_0058);
		write_row(2, j_type(21'd16, 5'd13), 5'd13, 32'h8000_005c, 32'h8000_0068);
		write_row(2, i_type(12'h041, 5'd11, 3'b000, 5'd14, OPC_JALR), 5'd14, 32'h8000_006c,
			32'h8000_1068); // target has bit 0 cleared
		write_row(3, i_type(CSR_MTVEC, 5'd11, 3'b001, 5'd16, OPC_SYSTEM), 5'd16, 32'd0,
			32'h8000_106c);
		write_row(3, i_type(CSR_MSTATUS, 5'd1, 3'b010, 5'd17, OPC_SYSTEM), 5'd17, 32'd0,
			32'h8000_1070);
		write_row(3, i_type(CSR_MSTATUS, 5'd8, 3'b011, 5'd18, OPC_SYSTEM), 5'd18, 32'd5,
			32'h8000_1074);
		write_row(3, i_type(CSR_MSTATUS, 5'd0, 3'b010, 5'd19, OPC_SYSTEM), 5'd19, 32'd4,
			32'h8000_1078);
		write_row(3, i_type(CSR_MTVEC, 5'd11, 3'b001, 5'd20, OPC_SYSTEM), 5'd20, 32'h8000_1028,
			32'h8000_107c);
		flow_row(4, 32'h0000_0073, 32'h8000_1028); // ecall lands on mtvec
		write_row(4, i_type(CSR_MEPC, 5'd0, 3'b010, 5'd21, OPC_SYSTEM), 5'd21, 32'h8000_107c,
			32'h8000_102c);
		write_row(4, i_type(CSR_MCAUSE, 5'd0, 3'b010, 5'd22, OPC_SYSTEM), 5'd22, 32'd11,
			32'h8000_1030);
		flow_row(4, 32'h3020_0073, 32'h8000_107c);
		stall_row(5, i_type(12'd99, 5'd0, 3'b000, 5'd10, OPC_IMM), 32'h8000_107c);
		stall_row(5, 32'h0010_0073, 32'h8000_107c);
		write_row(5, i_type(12'd1, 5'd12, 3'b000, 5'd23, OPC_IMM), 5'd23, 32'd6, 32'h8000_1080);
		halt_row(6, 32'h8000_1084, 32'h1234_5000);
	endtask

	task automatic check_value(string name, xlen_t expected, xlen_t actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
			beh_errors++;
		end
	endtask

	// ======================================================================
	// table walk and summary
	// ======================================================================
	initial begin
		inst = '0;
		inst_valid = 1'b0;
		build_table();
		cycle_limit = rows.size() + 10 + 20;
		@(posedge arst_n);
		@(posedge clk);
		#1;
		for (int i = 0; i < rows.size(); i++) begin
			#4;
			inst = rows[i].word;
			inst_valid = rows[i].valid;
			#30; // just before the next rising edge
			check_value("wb_en", xlen_t'(rows[i].wb_en), xlen_t'(wb_en));
			if (rows[i].wb_en) begin
				check_value("wb_addr", xlen_t'(rows[i].wb_addr), xlen_t'(wb_addr));
				check_value("wb_data", rows[i].wb_data, wb_data);
			end
			check_value("finished", xlen_t'(rows[i].fin), xlen_t'(finished));
			if (rows[i].chk_halt) begin
				check_value("halt_ret", rows[i].halt, halt_ret);
			end
			@(posedge clk);
			#1;
			check_value("pc", rows[i].pc_after, pc);
			if (i == rows.size() - 1 || rows[i + 1].beh != rows[i].beh) begin
				tests_run++;
				if (beh_errors == 0) begin
					$display("behavior %0d %s: passed", rows[i].beh, beh_names[rows[i].beh - 1]);
				end else begin
					tests_failed++;
					$display("behavior %0d %s: failed with %0d mismatches", rows[i].beh,
						beh_names[rows[i].beh - 1], beh_errors);
				end
				errors += beh_errors;
				beh_errors = 0;
			end
		end
		$display("%0d behaviors run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

//--- rv_core.f
src/rv_pkg.sv
src/decode_if.sv
src/decoder.sv
src/reg_file.sv
src/alu_unit.sv
src/csr_unit.sv
src/commit_merge.sv
src/rv_core.sv
tests/clock_gen.sv
tests/rv_core_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module rv_core_tb \
	-f rv_core.f -o rv_core_sim \
	&& ./obj_dir/rv_core_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
	&& echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL"; exit 1; }
